/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -Ilogic
TOP       := tb_exec_core
FILELIST  := all.f

SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)
BIN     := obj_dir/V$(TOP)

.PHONY: run clean

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) sim/exec_stim.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+logic
logic/cpu_pkg.sv
logic/id_type_r.sv
logic/reg_file.sv
logic/logic_unit.sv
logic/hilo_unit.sv
logic/cp0_unit.sv
logic/exec_core.sv
sim/tb_exec_core.sv

/* logic/cp0_unit.sv */
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/1ps

module cp0_unit
(
	input  wire            clk,
	input  wire            arst_n,
	input  wire            issue,
	input  cpu_pkg::dec_t  dec,
	input  cpu_pkg::word_t rdata2,
	input  cpu_pkg::word_t pc,
	output cpu_pkg::word_t cp0_rdata,
	output logic           exc,
	output logic           eret,
	output cpu_pkg::word_t epc
);

typedef enum logic [1:0]
{
	EV_NONE,
	EV_TRAP,
	EV_RETURN
} event_t;

cpu_pkg::word_t status;
cpu_pkg::word_t epc_q;
event_t         ev_next;
event_t         ev_q;

always_comb
begin
	ev_next = EV_NONE;
	if (issue && (dec.op == cpu_pkg::OP_INVALID))
		ev_next = EV_TRAP;
	else if (issue && (dec.op == cpu_pkg::OP_ERET))
		ev_next = EV_RETURN;
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		status <= '0;
		epc_q  <= '0;
		ev_q   <= EV_NONE;
	end
	else
	begin
		ev_q <= ev_next;
		if (ev_next == EV_TRAP)
		begin
			epc_q                  <= pc;
			status[`STATUS_EXL_BIT] <= 1'b1;
		end
		else if (ev_next == EV_RETURN)
			status[`STATUS_EXL_BIT] <= 1'b0;
		else if (issue && (dec.op == cpu_pkg::OP_MTC0))
		begin
			if (dec.cp0_sel == `CP0_REG_STATUS)
				status <= rdata2;
			else if (dec.cp0_sel == `CP0_REG_EPC)
				epc_q <= rdata2;
		end
	end
end

always_comb
begin
	case (dec.cp0_sel)
		`CP0_REG_STATUS: cp0_rdata = status;
		`CP0_REG_EPC:    cp0_rdata = epc_q;
		default:         cp0_rdata = '0; // Unimplemented
	endcase
end

assign exc  = (ev_q == EV_TRAP);
assign eret = (ev_q == EV_RETURN);
assign epc  = epc_q;

endmodule

`default_nettype wire

/* logic/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Primary opcodes
`define OPC_SPECIAL     6'b000000
`define OPC_SPECIAL2    6'b011100
`define OPC_COP0        6'b010000

// SPECIAL funct codes
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_XOR          6'b100110
`define FN_NOR          6'b100111
`define FN_MFHI         6'b010000
`define FN_MTHI         6'b010001
`define FN_MFLO         6'b010010
`define FN_MTLO         6'b010011
`define FN_MOVN         6'b001011
`define FN_MOVZ         6'b001010

// SPECIAL2 and COP0 funct codes
`define FN_MADDU        6'b000001
`define FN_ERET         6'b011000

// COP0 rs field
`define CP0_MF          5'b00000
`define CP0_MT          5'b00100
`define CP0_CO          5'b10000

// COP0 register numbers and Status bits
`define CP0_REG_STATUS  5'd12
`define CP0_REG_EPC     5'd14
`define STATUS_EXL_BIT  1

`endif

/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [3:0]
	{
		OP_NOP,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_MFHI,
		OP_MTHI,
		OP_MFLO,
		OP_MTLO,
		OP_MOVN,
		OP_MOVZ,
		OP_MADDU,
		OP_MFC0,
		OP_MTC0,
		OP_ERET,
		OP_INVALID
	} oper_t;

	typedef struct packed
	{
		oper_t     op;
		reg_addr_t raddr1;
		reg_addr_t raddr2;
		reg_addr_t waddr;
		logic      we;
		logic [4:0] cp0_sel; // COP0 register number
	} dec_t;

	typedef struct packed
	{
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} wb_t;

endpackage

`default_nettype wire

/* logic/exec_core.sv */
`default_nettype none
`timescale 1ns/1ps

module exec_core
(
	input  wire            clk,
	input  wire            arst_n,
	input  wire            issue,
	input  cpu_pkg::inst_t inst,
	input  cpu_pkg::word_t pc,
	input  wire            ld_valid,
	input  cpu_pkg::wb_t   ld_wb,
	output logic           retire_valid,
	output cpu_pkg::wb_t   retire,
	output logic           exc,
	output logic           eret,
	output cpu_pkg::word_t epc
);

cpu_pkg::dec_t  dec;
cpu_pkg::word_t rdata1;
cpu_pkg::word_t rdata2;
cpu_pkg::word_t hilo_rdata;
cpu_pkg::word_t cp0_rdata;
cpu_pkg::wb_t   inst_wb;
wire            rf_issue;

assign rf_issue = issue && (dec.op != cpu_pkg::OP_INVALID); // Trap retires through exc

id_type_r id_type_r_inst
(
	.inst (inst),
	.dec  (dec)
);

reg_file reg_file_inst
(
	.clk          (clk),
	.arst_n       (arst_n),
	.raddr1       (dec.raddr1),
	.raddr2       (dec.raddr2),
	.rdata1       (rdata1),
	.rdata2       (rdata2),
	.issue        (rf_issue),
	.inst_wb      (inst_wb),
	.ld_valid     (ld_valid),
	.ld_wb        (ld_wb),
	.retire_valid (retire_valid),
	.retire       (retire)
);

logic_unit logic_unit_inst
(
	.dec        (dec),
	.rdata1     (rdata1),
	.rdata2     (rdata2),
	.hilo_rdata (hilo_rdata),
	.cp0_rdata  (cp0_rdata),
	.inst_wb    (inst_wb)
);

hilo_unit hilo_unit_inst
(
	.clk        (clk),
	.arst_n     (arst_n),
	.issue      (issue),
	.dec        (dec),
	.rdata1     (rdata1),
	.rdata2     (rdata2),
	.hilo_rdata (hilo_rdata)
);

cp0_unit cp0_unit_inst
(
	.clk       (clk),
	.arst_n    (arst_n),
	.issue     (issue),
	.dec       (dec),
	.rdata2    (rdata2),
	.pc        (pc),
	.cp0_rdata (cp0_rdata),
	.exc       (exc),
	.eret      (eret),
	.epc       (epc)
);

endmodule

`default_nettype wire

/* logic/hilo_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module hilo_unit
(
	input  wire            clk,
	input  wire            arst_n,
	input  wire            issue,
	input  cpu_pkg::dec_t  dec,
	input  cpu_pkg::word_t rdata1,
	input  cpu_pkg::word_t rdata2,
	output cpu_pkg::word_t hilo_rdata
);

cpu_pkg::word_t hi;
cpu_pkg::word_t lo;
logic [63:0]    product;
logic [63:0]    acc;

assign product = {32'b0, rdata1} * {32'b0, rdata2}; // Unsigned 32x32
assign acc     = {hi, lo} + product; // Wraps at 64 bits

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		hi <= '0;
		lo <= '0;
	end
	else if (issue)
	begin
		case (dec.op)
			cpu_pkg::OP_MTHI:  hi <= rdata1;
			cpu_pkg::OP_MTLO:  lo <= rdata1;
			cpu_pkg::OP_MADDU:
			begin
				hi <= acc[63:32];
				lo <= acc[31:0];
			end
			default: ;
		endcase
	end
end

assign hilo_rdata = (dec.op == cpu_pkg::OP_MFHI) ? hi : lo;

endmodule

`default_nettype wire

/* logic/id_type_r.sv */
`include "cpu_params.svh"
`default_nettype none
`timescale 1ns/1ps

module id_type_r
(
	input  cpu_pkg::inst_t inst,
	output cpu_pkg::dec_t  dec
);

logic [5:0] opcode;
logic [5:0] funct;
cpu_pkg::reg_addr_t rs;
cpu_pkg::reg_addr_t rt;
cpu_pkg::reg_addr_t rd;

assign opcode = inst[31:26];
assign rs     = inst[25:21];
assign rt     = inst[20:16];
assign rd     = inst[15:11];
assign funct  = inst[5:0];

always_comb
begin
	dec.op      = cpu_pkg::OP_INVALID;
	dec.raddr1  = rs;
	dec.raddr2  = rt;
	dec.waddr   = rd;
	dec.we      = 1'b1;
	dec.cp0_sel = 5'b0;
	case (opcode)
		`OPC_SPECIAL:
		begin
			if (inst == 32'b0)
			begin
				dec.op     = cpu_pkg::OP_NOP;
				dec.raddr1 = 5'b0;
				dec.raddr2 = 5'b0;
				dec.waddr  = 5'b0;
				dec.we     = 1'b0;
			end
			else
			begin
				case (funct)
					`FN_AND:  dec.op = cpu_pkg::OP_AND;
					`FN_OR:   dec.op = cpu_pkg::OP_OR;
					`FN_XOR:  dec.op = cpu_pkg::OP_XOR;
					`FN_NOR:  dec.op = cpu_pkg::OP_NOR;
					`FN_MFHI: dec.op = cpu_pkg::OP_MFHI;
					`FN_MFLO: dec.op = cpu_pkg::OP_MFLO;
					`FN_MOVN: dec.op = cpu_pkg::OP_MOVN;
					`FN_MOVZ: dec.op = cpu_pkg::OP_MOVZ;
					`FN_MTHI:
					begin
						dec.op    = cpu_pkg::OP_MTHI;
						dec.we    = 1'b0;
						dec.waddr = 5'b0;
					end
					`FN_MTLO:
					begin
						dec.op    = cpu_pkg::OP_MTLO;
						dec.we    = 1'b0;
						dec.waddr = 5'b0;
					end
					default: dec.op = cpu_pkg::OP_INVALID;
				endcase
			end
		end
		`OPC_SPECIAL2:
		begin
			dec.we = 1'b0; // Result lands in HI:LO
			if (funct == `FN_MADDU)
				dec.op = cpu_pkg::OP_MADDU;
		end
		`OPC_COP0:
		begin
			dec.cp0_sel = rd;
			dec.raddr1  = 5'b0;
			dec.we      = 1'b0;
			case (rs)
				`CP0_MF:
				begin
					dec.op     = cpu_pkg::OP_MFC0;
					dec.we     = 1'b1;
					dec.waddr  = rt;
					dec.raddr2 = 5'b0;
				end
				`CP0_MT: dec.op = cpu_pkg::OP_MTC0;
				`CP0_CO: dec.op = (funct == `FN_ERET) ? cpu_pkg::OP_ERET : cpu_pkg::OP_INVALID;
				default: dec.op = cpu_pkg::OP_INVALID;
			endcase
		end
		default: dec.op = cpu_pkg::OP_INVALID;
	endcase
	if (dec.op == cpu_pkg::OP_INVALID)
		dec.we = 1'b0; // Trapping op never writes rd
end

endmodule

`default_nettype wire

/* logic/logic_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module logic_unit
(
	input  cpu_pkg::dec_t  dec,
	input  cpu_pkg::word_t rdata1,
	input  cpu_pkg::word_t rdata2,
	input  cpu_pkg::word_t hilo_rdata,
	input  cpu_pkg::word_t cp0_rdata,
	output cpu_pkg::wb_t   inst_wb
);

logic rt_zero;

assign rt_zero = (rdata2 == '0);

always_comb
begin
	inst_wb.we    = dec.we;
	inst_wb.waddr = dec.waddr;
	inst_wb.wdata = '0;
	case (dec.op)
		cpu_pkg::OP_AND: inst_wb.wdata = rdata1 & rdata2;
		cpu_pkg::OP_OR:  inst_wb.wdata = rdata1 | rdata2;
		cpu_pkg::OP_XOR: inst_wb.wdata = rdata1 ^ rdata2;
		cpu_pkg::OP_NOR: inst_wb.wdata = ~(rdata1 | rdata2);
		cpu_pkg::OP_MOVN:
		begin
			inst_wb.wdata = rdata1;
			inst_wb.we    = dec.we && !rt_zero; // Move only when rt nonzero
		end
		cpu_pkg::OP_MOVZ:
		begin
			inst_wb.wdata = rdata1;
			inst_wb.we    = dec.we && rt_zero;
		end
		cpu_pkg::OP_MFHI,
		cpu_pkg::OP_MFLO: inst_wb.wdata = hilo_rdata;
		cpu_pkg::OP_MFC0: inst_wb.wdata = cp0_rdata;
		default:          inst_wb.wdata = '0;
	endcase
end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none
`timescale 1ns/1ps

module reg_file
(
	input  wire                clk,
	input  wire                arst_n,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	output cpu_pkg::word_t     rdata1,
	output cpu_pkg::word_t     rdata2,
	input  wire                issue,
	input  cpu_pkg::wb_t       inst_wb,
	input  wire                ld_valid,
	input  cpu_pkg::wb_t       ld_wb,
	output logic               retire_valid,
	output cpu_pkg::wb_t       retire
);

cpu_pkg::word_t regs [1:31];
cpu_pkg::wb_t   wr;

// ##########################################################
// Write port arbitration
// ##########################################################

always_comb
begin
	wr = '0;
	if (issue && inst_wb.we)
		wr = inst_wb; // Instruction wins the port
	else if (ld_valid && !issue && ld_wb.we)
		wr = ld_wb;
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		for (int i = 1; i < 32; i++)
			regs[i] <= '0;
	end
	else if (wr.we && (wr.waddr != 5'd0))
		regs[wr.waddr] <= wr.wdata;
end

assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

// ##########################################################
// Retire record
// ##########################################################

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
		retire_valid <= 1'b0;
	else
		retire_valid <= issue;
end

always_ff @(posedge clk)
begin
	if (issue)
		retire <= inst_wb;
end

endmodule

`default_nettype wire

/* sim/exec_stim.txt */
# L <reg> <data> : load writeback into a general register
# I <pc> <inst> <class W/N/X/E> <reg> <value> : value is wdata for W, epc for X and E
L 01 F0F01234
L 02 0FF05678
L 04 FFFFFFFF
L 05 12345678
I 00000100 00223024 W 06 00F01230
I 00000104 00223825 W 07 FFF0567C
I 00000108 00224026 W 08 FF00444C
I 0000010C 00224827 W 09 000FA983
I 00000110 00220024 W 00 00F01230
I 00000114 00015025 W 0A F0F01234
I 00000118 00A4580B W 0B 12345678
I 0000011C 00A3600A W 0C 12345678
I 00000120 00A3680B N 00 00000000
I 00000124 00A4700A N 00 00000000
I 00000128 00200011 N 00 00000000
I 0000012C 00400013 N 00 00000000
I 00000130 00007810 W 0F F0F01234
I 00000134 00008012 W 10 0FF05678
I 00000138 70840001 N 00 00000000
I 0000013C 70810001 N 00 00000000
I 00000140 00009010 W 12 E1E02465
I 00000144 00009812 W 13 1F004445
I 00000148 40857000 N 00 00000000
I 0000014C 40147000 W 14 12345678
I 00000150 40154800 W 15 00000000
I 00000400 0020003F X 00 00000400
I 00000404 FC000000 X 00 00000404
I 00000408 40166000 W 16 00000002
I 0000040C 42000018 E 00 00000404
I 00000410 40176000 W 17 00000000
I 00000414 00000000 N 00 00000000

/* sim/tb_exec_core.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_exec_core;

logic               clk;
logic               arst_n;
logic               issue;
cpu_pkg::inst_t     inst;
cpu_pkg::word_t     pc;
logic               ld_valid;
cpu_pkg::wb_t       ld_wb;
logic               retire_valid;
cpu_pkg::wb_t       retire;
logic               exc;
logic               eret;
cpu_pkg::word_t     epc;

exec_core exec_core_inst
(
	.clk          (clk),
	.arst_n       (arst_n),
	.issue        (issue),
	.inst         (inst),
	.pc           (pc),
	.ld_valid     (ld_valid),
	.ld_wb        (ld_wb),
	.retire_valid (retire_valid),
	.retire       (retire),
	.exc          (exc),
	.eret         (eret),
	.epc          (epc)
);

always #4 clk = ~clk; // 8 ns period

// ##########################################################
// Checks
// ##########################################################

task automatic abort_run(input string why);
	$display("%s", why);
	$display("TEST FAIL");
	$fatal(1, "simulation stopped");
endtask

task automatic check_wb(input string name, input cpu_pkg::wb_t exp, input cpu_pkg::wb_t act);
	if (act !== exp)
		abort_run($sformatf(
			"ERR %s expected we=%0b waddr=%0d wdata=%h actual we=%0b waddr=%0d wdata=%h",
			name, exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata));
endtask

task automatic check_word(input string name, input cpu_pkg::word_t exp, input cpu_pkg::word_t act);
	if (act !== exp)
		abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
	if (act !== exp)
		abort_run($sformatf("ERR %s expected %0b actual %0b", name, exp, act));
endtask

// ##########################################################
// Drivers
// ##########################################################

task automatic load_reg(input cpu_pkg::reg_addr_t addr, input cpu_pkg::word_t data);
	@(posedge clk);
	ld_valid <= 1'b1;
	ld_wb    <= '{we: 1'b1, waddr: addr, wdata: data};
	@(posedge clk);
	ld_valid <= 1'b0;
	ld_wb    <= '0;
	@(negedge clk); // A load never retires
	check_flag($sformatf("load r%0d retire_valid", addr), 1'b0, retire_valid);
endtask

task automatic issue_inst(input cpu_pkg::word_t pc_v, input cpu_pkg::inst_t inst_v);
	int n;
	@(posedge clk);
	issue <= 1'b1;
	inst  <= inst_v;
	pc    <= pc_v;
	@(posedge clk);
	issue <= 1'b0;
	n = 0;
	do
	begin
		@(negedge clk); // Outputs settled here
		n++;
	end
	while (!(retire_valid || exc) && n < 20);
	if (!(retire_valid || exc))
		abort_run("No result arrived within 20 cycles after an issue");
endtask

task automatic check_result(input string name, input byte cls, input cpu_pkg::reg_addr_t addr,
	input cpu_pkg::word_t val);
	cpu_pkg::wb_t exp;
	exp = '{we: 1'b1, waddr: addr, wdata: val};
	check_flag({name, " exc"}, (cls == "X"), exc);
	check_flag({name, " retire_valid"}, (cls != "X"), retire_valid);
	check_flag({name, " eret"}, (cls == "E"), eret);
	case (cls)
		"W": check_wb(name, exp, retire);
		"N": check_flag({name, " we"}, 1'b0, retire.we);
		"X": check_word({name, " epc"}, val, epc);
		"E":
		begin
			check_flag({name, " we"}, 1'b0, retire.we);
			check_word({name, " epc"}, val, epc);
		end
		default: abort_run($sformatf("Unknown result class in %s of the stimulus file", name));
	endcase
endtask

// ##########################################################
// Main sequence
// ##########################################################

initial
begin
	int                 fd;
	int                 c;
	int                 n;
	int                 rows;
	byte                ch;
	byte                cls;
	cpu_pkg::word_t     pc_v;
	cpu_pkg::inst_t     inst_v;
	cpu_pkg::reg_addr_t addr_v;
	cpu_pkg::word_t     val_v;
	clk      = 1'b0;
	arst_n   = 1'b0;
	issue    = 1'b0;
	inst     = '0;
	pc       = '0;
	ld_valid = 1'b0;
	ld_wb    = '0;
	rows     = 0;
	repeat (3) @(posedge clk);
	arst_n <= 1'b1;
	fd = $fopen("sim/exec_stim.txt", "r");
	if (fd == 0)
		abort_run("Could not open the stimulus file sim/exec_stim.txt");
	c = $fgetc(fd);
	while (c != -1)
	begin
		ch = byte'(c);
		if (ch == "#")
		begin
			while (c != -1 && byte'(c) != "\n")
				c = $fgetc(fd); // Skip comment line
		end
		else if (ch == "L")
		begin
			n = $fscanf(fd, "%h %h", addr_v, val_v);
			if (n != 2)
				abort_run("Malformed load row in the stimulus file");
			rows++;
			load_reg(addr_v, val_v);
		end
		else if (ch == "I")
		begin
			n = $fscanf(fd, "%h %h %c %h %h", pc_v, inst_v, cls, addr_v, val_v);
			if (n != 5)
				abort_run("Malformed issue row in the stimulus file");
			rows++;
			issue_inst(pc_v, inst_v);
			check_result($sformatf("row %0d", rows), cls, addr_v, val_v);
		end
		else if (ch != " " && ch != "\t" && ch != "\n" && ch != "\r")
			abort_run("Unexpected character in the stimulus file");
		c = $fgetc(fd);
	end
	$fclose(fd);
	if (rows == 0)
		abort_run("The stimulus file holds no rows");
	else
	begin
		$display("TEST PASS");
		$finish;
	end
end

endmodule

`default_nettype wire
